/* dv/exec_core_tb.sv */
`timescale 1ns/1ps

module exec_core_tb;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic        dump_start;
	logic        busy;
	logic        illegal;
	logic        dump_valid;
	logic [4:0]  dump_addr;
	logic [31:0] dump_data;

	logic [31:0] model [32];	// Reference register file
	int          errors;
	int          checks;
	int          seed;

	exec_core dut (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dump_start  (dump_start),
		.busy        (busy),
		.illegal     (illegal),
		.dump_valid  (dump_valid),
		.dump_addr   (dump_addr),
		.dump_data   (dump_data)
	);

	always #2 clk = ~clk;	// 4 ns period

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	task automatic compare_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("MISMATCH at %0t: %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// Bounded wait for the core to go idle
	task automatic wait_idle();
		int t;
		t = 0;
		while (busy && t < 100) begin
			@(negedge clk);
			t++;
		end
		checks++;
		assert (!busy) else begin
			errors++;
			$display("ERROR at %0t: timeout, busy still high after 100 cycles", $time);
		end
	endtask

	function automatic logic [31:0] build_r(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt, input logic [4:0] sh);
		return {exec_pkg::op_rtype, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] build_i(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// Expected effect of one instruction word on the model
	task automatic model_exec(input logic [31:0] w, output logic legal);
		logic [5:0]  op;
		logic [5:0]  fn;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  dst;
		logic [4:0]  sh;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] se;
		logic [31:0] ze;
		logic [31:0] res;
		op = w[31:26];
		rs = w[25:21];
		rt = w[20:16];
		sh = w[10:6];
		fn = w[5:0];
		a = model[rs];
		b = model[rt];
		se = {{16{w[15]}}, w[15:0]};	// ADDIU, SLTI
		ze = {16'h0000, w[15:0]};	// Logic immediates
		legal = 1'b1;
		dst = rt;	// I-type target
		res = '0;
		case (op)
			exec_pkg::op_rtype: begin
				dst = w[15:11];
				case (fn)
					exec_pkg::fn_addu: res = a + b;
					exec_pkg::fn_subu: res = a - b;
					exec_pkg::fn_and:  res = a & b;
					exec_pkg::fn_or:   res = a | b;
					exec_pkg::fn_xor:  res = a ^ b;
					exec_pkg::fn_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					exec_pkg::fn_sll:  res = b << sh;
					exec_pkg::fn_srl:  res = b >> sh;
					default:           legal = 1'b0;
				endcase
			end
			exec_pkg::op_addiu: res = a + se;
			exec_pkg::op_slti:  res = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
			exec_pkg::op_andi:  res = a & ze;
			exec_pkg::op_ori:   res = a | ze;
			exec_pkg::op_xori:  res = a ^ ze;
			exec_pkg::op_lui:   res = {w[15:0], 16'h0000};
			default:            legal = 1'b0;
		endcase
		if (legal && dst != 5'd0) model[dst] = res;	// r0 stays zero
	endtask

	// One instruction with its EXEC checks
	task automatic run_instr(input logic [31:0] w);
		logic legal;
		model_exec(w, legal);
		wait_idle();
		@(negedge clk);
		instr = w;
		instr_valid = 1'b1;
		@(negedge clk);
		instr_valid = 1'b0;
		compare_value("busy", 32'd1, {31'd0, busy});	// In EXEC now
		compare_value("illegal", {31'd0, !legal}, {31'd0, illegal});
		wait_idle();
	endtask

	// Full register dump against the model
	task automatic read_all();
		int n;
		wait_idle();
		@(negedge clk);
		dump_start = 1'b1;
		@(negedge clk);
		dump_start = 1'b0;
		n = 0;
		while (dump_valid && n < 32) begin
			compare_value("busy", 32'd1, {31'd0, busy});	// High through the dump
			compare_value("dump_addr", n, {27'd0, dump_addr});
			compare_value($sformatf("dump_data r%0d", n), model[n[4:0]], dump_data);
			n++;
			@(negedge clk);
		end
		compare_value("dump_valid cycles", 32'd32, n);
		compare_value("dump_valid", 32'd0, {31'd0, dump_valid});	// Must end after r31
		compare_value("busy", 32'd0, {31'd0, busy});
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_dump();
		compare_value("busy", 32'd0, {31'd0, busy});
		compare_value("illegal", 32'd0, {31'd0, illegal});
		compare_value("dump_valid", 32'd0, {31'd0, dump_valid});
		read_all();
	endtask

	task automatic test_arith();
		run_instr(build_i(exec_pkg::op_addiu, 5'd1, 5'd0, 16'h0064));
		run_instr(build_i(exec_pkg::op_addiu, 5'd2, 5'd0, 16'hfffb));	// -5
		run_instr(build_i(exec_pkg::op_ori, 5'd3, 5'd0, 16'ha5a5));
		run_instr(build_i(exec_pkg::op_addiu, 5'd4, 5'd3, 16'h1234));
		run_instr(build_r(exec_pkg::fn_addu, 5'd5, 5'd1, 5'd2, 5'd0));
		run_instr(build_r(exec_pkg::fn_subu, 5'd6, 5'd2, 5'd1, 5'd0));
		run_instr(build_r(exec_pkg::fn_and, 5'd7, 5'd3, 5'd4, 5'd0));
		run_instr(build_r(exec_pkg::fn_or, 5'd8, 5'd3, 5'd2, 5'd0));
		run_instr(build_r(exec_pkg::fn_xor, 5'd9, 5'd4, 5'd2, 5'd0));
		run_instr(build_r(exec_pkg::fn_slt, 5'd10, 5'd2, 5'd1, 5'd0));	// Negative vs positive
		run_instr(build_r(exec_pkg::fn_slt, 5'd11, 5'd1, 5'd2, 5'd0));
		read_all();
	endtask

	task automatic test_imm_shift();
		run_instr(build_i(exec_pkg::op_andi, 5'd12, 5'd2, 16'h8f0f));	// Upper half clears
		run_instr(build_i(exec_pkg::op_xori, 5'd13, 5'd2, 16'h8001));
		run_instr(build_i(exec_pkg::op_slti, 5'd14, 5'd1, 16'hffff));
		run_instr(build_i(exec_pkg::op_slti, 5'd15, 5'd2, 16'h7fff));
		run_instr(build_i(exec_pkg::op_slti, 5'd16, 5'd2, 16'hfff0));
		run_instr(build_i(exec_pkg::op_lui, 5'd17, 5'd0, 16'hdead));
		run_instr(build_i(exec_pkg::op_ori, 5'd17, 5'd17, 16'hbeef));
		run_instr(build_r(exec_pkg::fn_sll, 5'd18, 5'd0, 5'd17, 5'd4));
		run_instr(build_r(exec_pkg::fn_sll, 5'd19, 5'd0, 5'd17, 5'd31));
		run_instr(build_r(exec_pkg::fn_srl, 5'd20, 5'd0, 5'd17, 5'd1));
		run_instr(build_r(exec_pkg::fn_srl, 5'd21, 5'd0, 5'd2, 5'd16));	// No sign fill
		run_instr(build_r(exec_pkg::fn_sll, 5'd22, 5'd0, 5'd3, 5'd0));
		read_all();
	endtask

	task automatic test_zero_illegal();
		run_instr(build_i(exec_pkg::op_addiu, 5'd0, 5'd1, 16'h0055));
		run_instr(build_r(exec_pkg::fn_addu, 5'd0, 5'd1, 5'd2, 5'd0));
		run_instr(build_i(6'h23, 5'd5, 5'd1, 16'h0004));	// Unsupported load opcode
		run_instr(build_r(6'h08, 5'd6, 5'd1, 5'd2, 5'd0));	// Jump-register funct
		run_instr(build_r(6'h3f, 5'd7, 5'd1, 5'd2, 5'd0));
		read_all();
	endtask

	task automatic test_busy_drop();
		logic        legal;
		logic [31:0] w_a;
		logic [31:0] w_b;
		w_a = build_i(exec_pkg::op_addiu, 5'd23, 5'd0, 16'h0123);
		w_b = build_i(exec_pkg::op_addiu, 5'd24, 5'd0, 16'h0456);
		model_exec(w_a, legal);	// Only the first word lands
		wait_idle();
		@(negedge clk);
		instr = w_a;
		instr_valid = 1'b1;
		@(negedge clk);
		compare_value("busy", 32'd1, {31'd0, busy});
		instr = w_b;	// Held through EXEC
		@(negedge clk);
		instr_valid = 1'b0;
		wait_idle();
		// Strobes in the middle of a dump
		@(negedge clk);
		dump_start = 1'b1;
		@(negedge clk);
		dump_start = 1'b0;
		repeat (5) @(negedge clk);
		compare_value("dump_valid", 32'd1, {31'd0, dump_valid});
		instr = build_i(exec_pkg::op_ori, 5'd25, 5'd0, 16'hffff);
		instr_valid = 1'b1;
		dump_start = 1'b1;
		@(negedge clk);
		instr_valid = 1'b0;
		dump_start = 1'b0;
		wait_idle();
		read_all();
	endtask

	task automatic test_random();
		logic [31:0] r;
		logic [31:0] q;
		logic [31:0] w;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [4:0]  sh;
		int          k;
		for (int i = 0; i < 200; i++) begin
			r = $random(seed);
			q = $random(seed);
			rs = r[4:0];
			rt = r[9:5];
			rd = r[14:10];
			sh = r[19:15];
			k = int'(q[7:0]) % 14;
			case (k)
				0:  w = build_r(exec_pkg::fn_addu, rd, rs, rt, 5'd0);
				1:  w = build_r(exec_pkg::fn_subu, rd, rs, rt, 5'd0);
				2:  w = build_r(exec_pkg::fn_and, rd, rs, rt, 5'd0);
				3:  w = build_r(exec_pkg::fn_or, rd, rs, rt, 5'd0);
				4:  w = build_r(exec_pkg::fn_xor, rd, rs, rt, 5'd0);
				5:  w = build_r(exec_pkg::fn_slt, rd, rs, rt, 5'd0);
				6:  w = build_r(exec_pkg::fn_sll, rd, 5'd0, rt, sh);
				7:  w = build_r(exec_pkg::fn_srl, rd, 5'd0, rt, sh);
				8:  w = build_i(exec_pkg::op_addiu, rt, rs, q[31:16]);
				9:  w = build_i(exec_pkg::op_slti, rt, rs, q[31:16]);
				10: w = build_i(exec_pkg::op_andi, rt, rs, q[31:16]);
				11: w = build_i(exec_pkg::op_ori, rt, rs, q[31:16]);
				12: w = build_i(exec_pkg::op_xori, rt, rs, q[31:16]);
				default: w = build_i(exec_pkg::op_lui, rt, 5'd0, q[31:16]);
			endcase
			run_instr(w);
		end
		read_all();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		dump_start = 1'b0;
		seed = 32'he4af;
		errors = 0;
		checks = 0;
		for (int i = 0; i < 32; i++) begin
			model[i[4:0]] = '0;	// Matches the reset state
		end
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		test_reset_dump();
		test_arith();
		test_imm_shift();
		test_zero_illegal();
		test_busy_drop();
		test_random();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* exec_core.f */
source/exec_pkg.sv
source/regfile_if.sv
source/reg_file.sv
source/alu_unit.sv
source/dump_counter.sv
source/exec_ctrl.sv
source/exec_core.sv
dv/exec_core_tb.sv

/* run.sh */
#!/bin/sh
# Build the exec_core testbench with Verilator, run it, decide on the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module exec_core_tb -f exec_core.f &&
out="$(./obj_dir/Vexec_core_tb)" &&
echo "$out" &&
echo "$out" | grep -qx "TEST PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* source/alu_unit.sv */
`timescale 1ns/1ps

// Integer ALU, purely combinational
module alu_unit (
	input  logic [exec_pkg::alu_op_w-1:0] op,
	input  logic [exec_pkg::data_w-1:0]   a,	// rs data
	input  logic [exec_pkg::data_w-1:0]   b,	// rt data or immediate
	input  logic [4:0]                    shamt,
	output logic [exec_pkg::data_w-1:0]   result
);

	logic [exec_pkg::data_w-1:0] sum;
	logic [exec_pkg::data_w-1:0] diff;
	logic                        lt;

	assign sum  = a + b;	// Wraps, no overflow trap
	assign diff = a - b;
	assign lt   = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			exec_pkg::alu_add: result = sum;
			exec_pkg::alu_sub: result = diff;
			exec_pkg::alu_and: result = a & b;
			exec_pkg::alu_or:  result = a | b;
			exec_pkg::alu_xor: result = a ^ b;
			exec_pkg::alu_slt: begin
				result = '0;
				result[0] = lt;	// 1 or 0
			end
			// Shifts act on b, as in MIPS
			exec_pkg::alu_sll: result = b << shamt;
			exec_pkg::alu_srl: result = b >> shamt;	// Logical, zero fill
			exec_pkg::alu_lui: begin
				result = {b[exec_pkg::imm_w-1:0], {exec_pkg::imm_w{1'b0}}};
			end
			default: result = '0;
		endcase
	end

endmodule

/* source/dump_counter.sv */
`timescale 1ns/1ps

// Register dump address
module dump_counter (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            dump_next,	// Advance one register
	output logic [exec_pkg::reg_addr_w-1:0] count,
	output logic                            dump_last	// Final register on port
);

	localparam logic [exec_pkg::reg_addr_w-1:0] last_addr =
		exec_pkg::reg_addr_w'(exec_pkg::num_regs - 1);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
		end else if (dump_next) begin
			count <= count + 1'b1;	// Wraps 31 -> 0, ready for next dump
		end
	end

	// Combinational, seen by the controller in the same cycle
	assign dump_last = (count == last_addr);

endmodule

/* source/exec_core.sv */
`timescale 1ns/1ps

// Top level of the execution core
module exec_core (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            instr_valid,
	input  logic [exec_pkg::data_w-1:0]     instr,
	input  logic                            dump_start,
	output logic                            busy,
	output logic                            illegal,	// Undefined op or function
	output logic                            dump_valid,
	output logic [exec_pkg::reg_addr_w-1:0] dump_addr,
	output logic [exec_pkg::data_w-1:0]     dump_data
);

	logic [exec_pkg::alu_op_w-1:0] alu_op;
	logic [exec_pkg::data_w-1:0]   alu_b;
	logic [4:0]                    shamt;
	logic [exec_pkg::data_w-1:0]   alu_result;
	logic                          dump_next;
	logic                          dump_last;

	regfile_if rf_bus ();	// Controller <-> register file

	exec_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.dump_start  (dump_start),
		.rf          (rf_bus.ctrl),
		.dump_count  (dump_addr),
		.dump_last   (dump_last),
		.dump_next   (dump_next),
		.alu_op      (alu_op),
		.alu_b       (alu_b),
		.shamt       (shamt),
		.alu_result  (alu_result),
		.busy        (busy),
		.illegal     (illegal),
		.dump_valid  (dump_valid)
	);

	dump_counter u_dump_cnt (
		.clk       (clk),
		.rst_n     (rst_n),
		.dump_next (dump_next),
		.count     (dump_addr),	// Also the dump address output
		.dump_last (dump_last)
	);

	reg_file u_rf (
		.clk   (clk),
		.rst_n (rst_n),
		.rf    (rf_bus.mem)
	);

	alu_unit u_alu (
		.op     (alu_op),
		.a      (rf_bus.rd_data_a),
		.b      (alu_b),
		.shamt  (shamt),
		.result (alu_result)
	);

	assign dump_data = rf_bus.rd_data_a;	// Port A carries the dump

endmodule

/* source/exec_ctrl.sv */
`timescale 1ns/1ps

// Controller: FSM, instruction register, decode, writeback
module exec_ctrl (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            instr_valid,	// One-cycle strobe
	input  exec_pkg::instr_t                instr,
	input  logic                            dump_start,	// One-cycle strobe
	regfile_if.ctrl                         rf,
	input  logic [exec_pkg::reg_addr_w-1:0] dump_count,
	input  logic                            dump_last,
	output logic                            dump_next,
	output logic [exec_pkg::alu_op_w-1:0]   alu_op,
	output logic [exec_pkg::data_w-1:0]     alu_b,
	output logic [4:0]                      shamt,
	input  logic [exec_pkg::data_w-1:0]     alu_result,
	output logic                            busy,
	output logic                            illegal,
	output logic                            dump_valid
);

	logic [exec_pkg::st_w-1:0]   state;
	logic [exec_pkg::st_w-1:0]   state_nxt;
	exec_pkg::instr_t            ir;	// Instruction register
	logic                        legal;
	logic [exec_pkg::data_w-1:0] imm_sext;
	logic [exec_pkg::data_w-1:0] imm_zext;

	//////////////////////////////////////////////////////////////////////
	// State machine
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			exec_pkg::st_idle: begin
				if (instr_valid) state_nxt = exec_pkg::st_exec;	// Instruction wins
				else if (dump_start) state_nxt = exec_pkg::st_dump;
			end
			exec_pkg::st_exec: state_nxt = exec_pkg::st_idle;	// Single cycle
			exec_pkg::st_dump: begin
				if (dump_last) state_nxt = exec_pkg::st_idle;
			end
			default: state_nxt = exec_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) state <= exec_pkg::st_idle;
		else        state <= state_nxt;
	end

	// Capture only when accepted
	always_ff @(posedge clk) begin
		if (state == exec_pkg::st_idle && instr_valid) ir <= instr;
	end

	//////////////////////////////////////////////////////////////////////
	// Decode
	//////////////////////////////////////////////////////////////////////

	assign imm_sext = {{(exec_pkg::data_w - exec_pkg::imm_w){ir.i_fmt.imm[exec_pkg::imm_w-1]}},
		ir.i_fmt.imm};
	assign imm_zext = {{(exec_pkg::data_w - exec_pkg::imm_w){1'b0}}, ir.i_fmt.imm};

	always_comb begin
		legal      = 1'b1;
		alu_op     = exec_pkg::alu_add;
		alu_b      = imm_zext;
		rf.wr_addr = ir.i_fmt.rt;	// I-type writes rt
		case (ir.r_fmt.opcode)
			exec_pkg::op_rtype: begin
				alu_b      = rf.rd_data_b;
				rf.wr_addr = ir.r_fmt.rd;
				case (ir.r_fmt.funct)
					exec_pkg::fn_addu: alu_op = exec_pkg::alu_add;
					exec_pkg::fn_subu: alu_op = exec_pkg::alu_sub;
					exec_pkg::fn_and:  alu_op = exec_pkg::alu_and;
					exec_pkg::fn_or:   alu_op = exec_pkg::alu_or;
					exec_pkg::fn_xor:  alu_op = exec_pkg::alu_xor;
					exec_pkg::fn_slt:  alu_op = exec_pkg::alu_slt;
					exec_pkg::fn_sll:  alu_op = exec_pkg::alu_sll;
					exec_pkg::fn_srl:  alu_op = exec_pkg::alu_srl;
					default:           legal  = 1'b0;	// Unknown function
				endcase
			end
			exec_pkg::op_addiu: begin
				alu_op = exec_pkg::alu_add;
				alu_b  = imm_sext;
			end
			exec_pkg::op_slti: begin
				alu_op = exec_pkg::alu_slt;
				alu_b  = imm_sext;
			end
			exec_pkg::op_andi: alu_op = exec_pkg::alu_and;	// Zero-extended imm
			exec_pkg::op_ori:  alu_op = exec_pkg::alu_or;
			exec_pkg::op_xori: alu_op = exec_pkg::alu_xor;
			exec_pkg::op_lui:  alu_op = exec_pkg::alu_lui;	// ALU moves imm up
			default:           legal  = 1'b0;
		endcase
	end

	assign shamt = ir.r_fmt.shamt;

	//////////////////////////////////////////////////////////////////////
	// Register file steering and status
	//////////////////////////////////////////////////////////////////////

	// Port A goes to the counter while dumping
	assign rf.rd_addr_a = (state == exec_pkg::st_dump) ? dump_count : ir.r_fmt.rs;
	assign rf.rd_addr_b = ir.r_fmt.rt;
	assign rf.wr_data   = alu_result;
	assign rf.wr_en     = (state == exec_pkg::st_exec) && legal;	// Lands on exit edge

	assign illegal    = (state == exec_pkg::st_exec) && !legal;
	assign busy       = (state != exec_pkg::st_idle);
	assign dump_valid = (state == exec_pkg::st_dump);
	assign dump_next  = dump_valid;

endmodule

/* source/exec_pkg.sv */
package exec_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths
	//////////////////////////////////////////////////////////////////////

	localparam int data_w     = 32;	// Register and datapath width
	localparam int reg_addr_w = 5;	// Register number
	localparam int num_regs   = 32;
	localparam int imm_w      = 16;	// I-type immediate
	localparam int alu_op_w   = 4;

	// Controller state codes
	localparam int st_w = 2;
	localparam logic [st_w-1:0] st_idle = 2'd0;
	localparam logic [st_w-1:0] st_exec = 2'd1;	// One cycle per instruction
	localparam logic [st_w-1:0] st_dump = 2'd2;	// 32 cycles, one register each

	//////////////////////////////////////////////////////////////////////
	// Opcodes and function codes, MIPS encoding
	//////////////////////////////////////////////////////////////////////

	localparam logic [5:0] op_rtype = 6'h00;	// Function field selects op
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_slti  = 6'h0a;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_xori  = 6'h0e;
	localparam logic [5:0] op_lui   = 6'h0f;

	localparam logic [5:0] fn_sll  = 6'h00;
	localparam logic [5:0] fn_srl  = 6'h02;
	localparam logic [5:0] fn_addu = 6'h21;
	localparam logic [5:0] fn_subu = 6'h23;
	localparam logic [5:0] fn_and  = 6'h24;
	localparam logic [5:0] fn_or   = 6'h25;
	localparam logic [5:0] fn_xor  = 6'h26;
	localparam logic [5:0] fn_slt  = 6'h2a;

	// ALU operations
	localparam logic [alu_op_w-1:0] alu_add = 4'd0;
	localparam logic [alu_op_w-1:0] alu_sub = 4'd1;
	localparam logic [alu_op_w-1:0] alu_and = 4'd2;
	localparam logic [alu_op_w-1:0] alu_or  = 4'd3;
	localparam logic [alu_op_w-1:0] alu_xor = 4'd4;
	localparam logic [alu_op_w-1:0] alu_slt = 4'd5;	// Signed compare
	localparam logic [alu_op_w-1:0] alu_sll = 4'd6;
	localparam logic [alu_op_w-1:0] alu_srl = 4'd7;
	localparam logic [alu_op_w-1:0] alu_lui = 4'd8;

	//////////////////////////////////////////////////////////////////////
	// Instruction word, two views of the same 32 bits
	//////////////////////////////////////////////////////////////////////

	typedef union packed {
		struct packed {
			logic [5:0]            opcode;
			logic [reg_addr_w-1:0] rs;
			logic [reg_addr_w-1:0] rt;
			logic [reg_addr_w-1:0] rd;	// Destination for R-type
			logic [4:0]            shamt;
			logic [5:0]            funct;
		} r_fmt;
		struct packed {
			logic [5:0]            opcode;
			logic [reg_addr_w-1:0] rs;
			logic [reg_addr_w-1:0] rt;	// Destination for I-type
			logic [imm_w-1:0]      imm;
		} i_fmt;
	} instr_t;

endpackage

/* source/reg_file.sv */
`timescale 1ns/1ps

// 32 x 32 register file
module reg_file (
	input  logic clk,
	input  logic rst_n,
	regfile_if.mem rf
);

	logic [exec_pkg::data_w-1:0] regs [exec_pkg::num_regs];	// Storage array

	//////////////////////////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < exec_pkg::num_regs; i++) begin
				regs[i] <= '0;	// All registers start at zero
			end
		end else if (rf.wr_en && (rf.wr_addr != '0)) begin
			regs[rf.wr_addr] <= rf.wr_data;	// r0 never written
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Read ports, combinational
	//////////////////////////////////////////////////////////////////////

	// r0 reads zero regardless of storage
	always_comb begin
		if (rf.rd_addr_a == '0) begin
			rf.rd_data_a = '0;
		end else begin
			rf.rd_data_a = regs[rf.rd_addr_a];
		end
	end

	always_comb begin
		if (rf.rd_addr_b == '0) begin
			rf.rd_data_b = '0;
		end else begin
			rf.rd_data_b = regs[rf.rd_addr_b];
		end
	end

endmodule

/* source/regfile_if.sv */
`timescale 1ns/1ps

// Two read ports, one write port
interface regfile_if;

	logic [exec_pkg::reg_addr_w-1:0] rd_addr_a;	// Also used by the dump
	logic [exec_pkg::reg_addr_w-1:0] rd_addr_b;
	logic [exec_pkg::data_w-1:0]     rd_data_a;
	logic [exec_pkg::data_w-1:0]     rd_data_b;
	logic                            wr_en;
	logic [exec_pkg::reg_addr_w-1:0] wr_addr;
	logic [exec_pkg::data_w-1:0]     wr_data;

	// Controller side
	modport ctrl (
		output rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
		input  rd_data_a, rd_data_b
	);

	// Register file side
	modport mem (
		input  rd_addr_a, rd_addr_b, wr_en, wr_addr, wr_data,
		output rd_data_a, rd_data_b
	);

endinterface
